// File: logic/core_pkg.sv
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  opcode_t;

    // what the decoder made of the latched instruction
    typedef enum logic [3:0] {
        op_alu_imm,
        op_alu_reg,
        op_lui,
        op_jal,
        op_jalr,
        op_branch,
        op_load,
        op_store,
        op_halt,
        op_illegal
    } op_class_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_xor,
        alu_and,
        alu_or,
        alu_slt,
        alu_sltu,
        alu_none
    } alu_op_e;

    typedef enum logic [3:0] {
        state_init,
        state_fetch,
        state_fetch_wait,
        state_decode,
        state_execute,
        state_load,
        state_load_wait,
        state_store,
        state_retire,
        state_halted
    } core_state_e;

    // RV32I major opcodes, auipc left out on purpose
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_op     = 7'b0110011;
    localparam opcode_t opc_lui    = 7'b0110111;
    localparam opcode_t opc_jal    = 7'b1101111;
    localparam opcode_t opc_jalr   = 7'b1100111;
    localparam opcode_t opc_branch = 7'b1100011;
    localparam opcode_t opc_load   = 7'b0000011;
    localparam opcode_t opc_store  = 7'b0100011;
    localparam opcode_t opc_system = 7'b1110011;

    // system immediate that stops the core
    localparam logic [11:0] halt_imm = 12'd1;

    localparam funct3_t f3_add_sub = 3'd0;
    localparam funct3_t f3_sll     = 3'd1;
    localparam funct3_t f3_slt     = 3'd2;
    localparam funct3_t f3_sltu    = 3'd3;
    localparam funct3_t f3_xor     = 3'd4;
    localparam funct3_t f3_srl_sra = 3'd5;
    localparam funct3_t f3_or      = 3'd6;
    localparam funct3_t f3_and     = 3'd7;

    localparam funct3_t f3_beq  = 3'd0;
    localparam funct3_t f3_bne  = 3'd1;
    localparam funct3_t f3_blt  = 3'd4;
    localparam funct3_t f3_bge  = 3'd5;
    localparam funct3_t f3_bltu = 3'd6;
    localparam funct3_t f3_bgeu = 3'd7;

    localparam word_t pc_step = 32'd4;

endpackage

// File: logic/core_sequencer.sv
`timescale 1ns/1ps

module core_sequencer #(
    parameter int address_width = 16
) (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     run,
    decoded_if.sequencer_side        seq,
    input  core_pkg::word_t          alu_result,
    input  logic                     branch_taken,
    input  core_pkg::word_t          rs2_value,
    input  core_pkg::word_t          inst_ram_read_result,
    input  core_pkg::word_t          data_ram_read_result,
    output logic                     latch_inst,
    output core_pkg::word_t          inst,
    output core_pkg::word_t          pc,
    output logic [address_width-1:0] inst_ram_address,
    output logic [address_width-1:0] data_ram_address,
    output core_pkg::word_t          data_ram_write_data,
    output logic                     data_ram_write,
    output logic                     halted,
    output logic                     write_enable,
    output core_pkg::reg_addr_t      write_addr,
    output core_pkg::word_t          write_data
);
    import core_pkg::*;

    core_state_e state;
    word_t       pc_plus_step;
    word_t       next_pc;
    word_t       rd_value;
    logic        writes_rd;

    // fetched word goes straight to the decoder, which latches it in decode
    assign inst       = inst_ram_read_result;
    assign latch_inst = run && (state == state_decode);

    assign pc_plus_step = pc + pc_step;

    always_comb begin
        case (seq.op_class)
            op_jal, op_jalr: next_pc = {alu_result[31:1], 1'b0};
            op_branch:       next_pc = branch_taken ? alu_result : pc_plus_step;
            default:         next_pc = pc_plus_step;
        endcase
    end

    always_comb begin
        case (seq.op_class)
            op_jal, op_jalr: rd_value = pc_plus_step;
            op_load:         rd_value = data_ram_read_result;
            default:         rd_value = alu_result;
        endcase
    end

    assign writes_rd = (seq.op_class == op_alu_imm) || (seq.op_class == op_alu_reg) ||
                       (seq.op_class == op_lui) || (seq.op_class == op_jal) ||
                       (seq.op_class == op_jalr) || (seq.op_class == op_load);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state            <= state_init;
            pc               <= '0;
            inst_ram_address <= '0;
            halted           <= 1'b0;
            data_ram_write   <= 1'b0;
            write_enable     <= 1'b0;
        end else begin
            // both strobes are single clock pulses, even when run drops
            data_ram_write <= run && (state == state_store);
            write_enable   <= run && (state == state_retire) && writes_rd;
            if (run) begin
                case (state)
                    state_init: begin
                        pc    <= '0;
                        state <= state_fetch;
                    end
                    state_fetch: begin
                        inst_ram_address <= pc[address_width-1:0];
                        state            <= state_fetch_wait;
                    end
                    state_fetch_wait: state <= state_decode;
                    state_decode:     state <= state_execute;
                    state_execute: begin
                        case (seq.op_class)
                            op_halt: begin
                                halted <= 1'b1;
                                state  <= state_halted;
                            end
                            op_load:  state <= state_load;
                            op_store: state <= state_store;
                            default:  state <= state_retire;
                        endcase
                    end
                    state_load:      state <= state_load_wait;
                    state_load_wait: state <= state_retire;
                    state_store:     state <= state_retire;
                    state_retire: begin
                        pc    <= next_pc;
                        state <= state_fetch;
                    end
                    state_halted: state <= state_halted;
                    default:      state <= state_init;
                endcase
            end
        end
    end

    // data path registers, loaded alongside the control above
    always_ff @(posedge clock) begin
        if (run) begin
            if ((state == state_load) || (state == state_store)) begin
                data_ram_address <= alu_result[address_width-1:0];
            end
            if (state == state_store) begin
                data_ram_write_data <= rs2_value;
            end
            if (state == state_retire) begin
                write_addr <= seq.rd;
                write_data <= rd_value;
            end
        end
    end

endmodule

// File: logic/decoded_if.sv
`timescale 1ns/1ps

interface decoded_if;
    import core_pkg::*;

    op_class_e op_class;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    funct3_t   funct3;
    // instruction bit 30, picks sub and sra
    logic      alt;
    word_t     imm;

    modport decoder_side (
        output op_class, rs1, rs2, rd, funct3, alt, imm
    );

    modport execute_side (
        input op_class, funct3, alt, imm
    );

    modport sequencer_side (
        input op_class, rd
    );

    modport regs_side (
        input rs1, rs2
    );

endinterface

// File: logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    decoded_if.execute_side dec,
    input  core_pkg::word_t pc,
    input  core_pkg::word_t rs1_value,
    input  core_pkg::word_t rs2_value,
    output core_pkg::word_t alu_result,
    output logic            branch_taken
);
    import core_pkg::*;

    alu_op_e    alu_op;
    word_t      operand1;
    word_t      operand2;
    logic [4:0] shamt;
    logic       condition;

    // operator selection, everything that is not arithmetic just adds
    always_comb begin
        alu_op = alu_add;
        case (dec.op_class)
            op_alu_imm, op_alu_reg: begin
                case (dec.funct3)
                    f3_add_sub: begin
                        // bit 30 of an addi is part of the immediate
                        if ((dec.op_class == op_alu_reg) && dec.alt) begin
                            alu_op = alu_sub;
                        end else begin
                            alu_op = alu_add;
                        end
                    end
                    f3_sll:     alu_op = alu_sll;
                    f3_slt:     alu_op = alu_slt;
                    f3_sltu:    alu_op = alu_sltu;
                    f3_xor:     alu_op = alu_xor;
                    f3_srl_sra: alu_op = dec.alt ? alu_sra : alu_srl;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                endcase
            end
            op_halt, op_illegal: alu_op = alu_none;
            default:             alu_op = alu_add;
        endcase
    end

    always_comb begin
        case (dec.op_class)
            op_alu_reg: begin
                operand1 = rs1_value;
                operand2 = rs2_value;
            end
            op_lui: begin
                operand1 = dec.imm;
                operand2 = '0;
            end
            op_jal, op_branch: begin
                operand1 = pc;
                operand2 = dec.imm;
            end
            default: begin
                // alu_imm, load, store and jalr
                operand1 = rs1_value;
                operand2 = dec.imm;
            end
        endcase
    end

    assign shamt = operand2[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  alu_result = operand1 + operand2;
            alu_sub:  alu_result = operand1 - operand2;
            alu_sll:  alu_result = operand1 << shamt;
            alu_srl:  alu_result = operand1 >> shamt;
            alu_sra:  alu_result = word_t'($signed(operand1) >>> shamt);
            alu_xor:  alu_result = operand1 ^ operand2;
            alu_and:  alu_result = operand1 & operand2;
            alu_or:   alu_result = operand1 | operand2;
            alu_slt:  alu_result = {31'b0, $signed(operand1) < $signed(operand2)};
            alu_sltu: alu_result = {31'b0, operand1 < operand2};
            default:  alu_result = '0;
        endcase
    end

    // branch compare always works on the two register operands
    always_comb begin
        case (dec.funct3)
            f3_beq:  condition = (rs1_value == rs2_value);
            f3_bne:  condition = (rs1_value != rs2_value);
            f3_blt:  condition = ($signed(rs1_value) < $signed(rs2_value));
            f3_bge:  condition = ($signed(rs1_value) >= $signed(rs2_value));
            f3_bltu: condition = (rs1_value < rs2_value);
            f3_bgeu: condition = (rs1_value >= rs2_value);
            default: condition = 1'b0;
        endcase
    end

    assign branch_taken = (dec.op_class == op_branch) && condition;

endmodule

// File: logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic            clock,
    input  logic            reset_n,
    input  logic            latch_inst,
    input  core_pkg::word_t inst,
    decoded_if.decoder_side dec
);
    import core_pkg::*;

    word_t     inst_reg;
    opcode_t   opcode;
    op_class_e op_class;
    word_t     imm;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            // all zeros decodes as illegal until the first fetch lands
            inst_reg <= '0;
        end else if (latch_inst) begin
            inst_reg <= inst;
        end
    end

    assign opcode = inst_reg[6:0];

    always_comb begin
        case (opcode)
            opc_op_imm: op_class = op_alu_imm;
            opc_op:     op_class = op_alu_reg;
            opc_lui:    op_class = op_lui;
            opc_jal:    op_class = op_jal;
            opc_jalr:   op_class = op_jalr;
            opc_branch: op_class = op_branch;
            opc_load:   op_class = op_load;
            opc_store:  op_class = op_store;
            opc_system: begin
                // only the halt form of the system opcode is supported
                if (inst_reg[31:20] == halt_imm) begin
                    op_class = op_halt;
                end else begin
                    op_class = op_illegal;
                end
            end
            default:    op_class = op_illegal;
        endcase
    end

    // immediate format follows the opcode
    always_comb begin
        case (opcode)
            opc_store: begin
                imm = {{20{inst_reg[31]}}, inst_reg[31:25], inst_reg[11:7]};
            end
            opc_branch: begin
                imm = {{19{inst_reg[31]}}, inst_reg[31], inst_reg[7],
                       inst_reg[30:25], inst_reg[11:8], 1'b0};
            end
            opc_lui: begin
                imm = {inst_reg[31:12], 12'b0};
            end
            opc_jal: begin
                imm = {{11{inst_reg[31]}}, inst_reg[31], inst_reg[19:12],
                       inst_reg[20], inst_reg[30:21], 1'b0};
            end
            default: begin
                // I format, covers op-imm, jalr, load and system
                imm = {{20{inst_reg[31]}}, inst_reg[31:20]};
            end
        endcase
    end

    assign dec.op_class = op_class;
    assign dec.rs1      = inst_reg[19:15];
    assign dec.rs2      = inst_reg[24:20];
    assign dec.rd       = inst_reg[11:7];
    assign dec.funct3   = inst_reg[14:12];
    assign dec.alt      = inst_reg[30];
    assign dec.imm      = imm;

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                clock,
    decoded_if.regs_side        regs,
    input  logic                write_enable,
    input  core_pkg::reg_addr_t write_addr,
    input  core_pkg::word_t     write_data,
    output core_pkg::word_t     rs1_value,
    output core_pkg::word_t     rs2_value
);
    import core_pkg::*;

    word_t bank [32];

    // x0 is never written, so its entry stays unused
    always_ff @(posedge clock) begin
        if (write_enable && (write_addr != '0)) begin
            bank[write_addr] <= write_data;
        end
    end

    assign rs1_value = (regs.rs1 == '0) ? '0 : bank[regs.rs1];
    assign rs2_value = (regs.rs2 == '0) ? '0 : bank[regs.rs2];

endmodule

// File: logic/shader_core.sv
`timescale 1ns/1ps

module shader_core #(
    parameter int address_width = 16
) (
    input  logic                     clock,
    input  logic                     reset_n,
    input  logic                     run,
    output logic                     halted,
    output logic [address_width-1:0] inst_ram_address,
    input  core_pkg::word_t          inst_ram_read_result,
    output logic [address_width-1:0] data_ram_address,
    output core_pkg::word_t          data_ram_write_data,
    output logic                     data_ram_write,
    input  core_pkg::word_t          data_ram_read_result
);
    import core_pkg::*;

    word_t     inst;
    word_t     pc;
    word_t     rs1_value;
    word_t     rs2_value;
    word_t     alu_result;
    word_t     write_data;
    reg_addr_t write_addr;
    logic      latch_inst;
    logic      branch_taken;
    logic      write_enable;

    decoded_if decoded ();

    inst_decoder u_decoder (
        .clock      (clock),
        .reset_n    (reset_n),
        .latch_inst (latch_inst),
        .inst       (inst),
        .dec        (decoded)
    );

    register_file u_regs (
        .clock        (clock),
        .regs         (decoded),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value)
    );

    execute_unit u_execute (
        .dec          (decoded),
        .pc           (pc),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    core_sequencer #(
        .address_width (address_width)
    ) u_sequencer (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .seq                  (decoded),
        .alu_result           (alu_result),
        .branch_taken         (branch_taken),
        .rs2_value            (rs2_value),
        .inst_ram_read_result (inst_ram_read_result),
        .data_ram_read_result (data_ram_read_result),
        .latch_inst           (latch_inst),
        .inst                 (inst),
        .pc                   (pc),
        .inst_ram_address     (inst_ram_address),
        .data_ram_address     (data_ram_address),
        .data_ram_write_data  (data_ram_write_data),
        .data_ram_write       (data_ram_write),
        .halted               (halted),
        .write_enable         (write_enable),
        .write_addr           (write_addr),
        .write_data           (write_data)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module shader_core_tb -o shader_core_sim

./obj_dir/shader_core_sim 2>&1 | tee sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
    echo "run_sim: pass"
else
    echo "run_sim: fail"
    exit 1
fi

// File: src.f
logic/core_pkg.sv
logic/decoded_if.sv
logic/inst_decoder.sv
logic/register_file.sv
logic/execute_unit.sv
logic/core_sequencer.sv
logic/shader_core.sv
verif/shader_core_chk.sv
verif/shader_core_tb.sv

// File: verif/program_input.txt
# tag address word: I instruction word, D initial data word, E expected final data word
# addresses are byte addresses in hex, text after the word is ignored
I 0000 FF900093 addi x1, x0, -7
I 0004 00300113 addi x2, x0, 3
I 0008 002081B3 add x3, x1, x2
I 000C 20302023 sw x3, 0x200(x0)
I 0010 402081B3 sub x3, x1, x2
I 0014 20302223 sw x3, 0x204(x0)
I 0018 002091B3 sll x3, x1, x2
I 001C 20302423 sw x3, 0x208(x0)
I 0020 0030D193 srli x3, x1, 3
I 0024 20302623 sw x3, 0x20c(x0)
I 0028 4020D1B3 sra x3, x1, x2
I 002C 20302823 sw x3, 0x210(x0)
I 0030 0F00C193 xori x3, x1, 0x0f0
I 0034 20302A23 sw x3, 0x214(x0)
I 0038 0020F1B3 and x3, x1, x2
I 003C 20302C23 sw x3, 0x218(x0)
I 0040 4C016193 ori x3, x2, 0x4c0
I 0044 20302E23 sw x3, 0x21c(x0)
I 0048 0020A1B3 slt x3, x1, x2
I 004C 22302023 sw x3, 0x220(x0)
I 0050 0050B193 sltiu x3, x1, 5
I 0054 22302223 sw x3, 0x224(x0)
I 0058 ABCDE1B7 lui x3, 0xabcde
I 005C 22302423 sw x3, 0x228(x0)
I 0060 10002503 lw x10, 0x100(x0)
I 0064 10402583 lw x11, 0x104(x0)
I 0068 00B50633 add x12, x10, x11
I 006C FD058693 addi x13, x11, -48
I 0070 10C02023 sw x12, 0x100(x0)
I 0074 10D02223 sw x13, 0x104(x0)
I 0078 00210463 beq x2, x2, +8 taken
I 007C 06C0006F jal x0, fail
I 0080 00209463 bne x1, x2, +8 taken
I 0084 0640006F jal x0, fail
I 0088 0020C463 blt x1, x2, +8 taken
I 008C 05C0006F jal x0, fail
I 0090 00115463 bge x2, x1, +8 taken
I 0094 0540006F jal x0, fail
I 0098 00116463 bltu x2, x1, +8 taken
I 009C 04C0006F jal x0, fail
I 00A0 0020F463 bgeu x1, x2, +8 taken
I 00A4 0440006F jal x0, fail
I 00A8 04208063 beq x1, x2, fail not taken
I 00AC 02211E63 bne x2, x2, fail not taken
I 00B0 02114C63 blt x2, x1, fail not taken
I 00B4 0220DA63 bge x1, x2, fail not taken
I 00B8 0220E863 bltu x1, x2, fail not taken
I 00BC 02117663 bgeu x2, x1, fail not taken
I 00C0 22202623 sw x2, 0x22c(x0) marker
I 00C4 008003EF jal x7, +8
I 00C8 0200006F jal x0, fail
I 00CC 0D5004E7 jalr x9, 0xd5(x0)
I 00D0 0180006F jal x0, fail
I 00D4 22702823 sw x7, 0x230(x0)
I 00D8 22902A23 sw x9, 0x234(x0)
I 00DC 00001397 auipc x7, 1 illegal
I 00E0 22702C23 sw x7, 0x238(x0)
I 00E4 00100073 halt
I 00E8 24102023 fail: sw x1, 0x240(x0)
I 00EC 00100073 halt
D 0100 7FFFFFF0
D 0104 00000025
D 0240 12345678
E 0200 FFFFFFFC
E 0204 FFFFFFF6
E 0208 FFFFFFC8
E 020C 1FFFFFFF
E 0210 FFFFFFFF
E 0214 FFFFFF09
E 0218 00000001
E 021C 000004C3
E 0220 00000001
E 0224 00000000
E 0228 ABCDE000
E 0100 80000015
E 0104 FFFFFFF5
E 022C 00000003
E 0230 000000C8
E 0234 000000D0
E 0238 000000C8
E 0240 12345678

// File: verif/shader_core_chk.sv
`timescale 1ns/1ps

module shader_core_chk (
    input logic clock,
    input logic reset_n,
    input logic halted,
    input logic data_ram_write
);

    // store strobe is one clock wide
    assert property (@(posedge clock) disable iff (!reset_n)
        data_ram_write |=> !data_ram_write)
        else $error("data_ram_write high for two clocks in a row");

    assert property (@(posedge clock) disable iff (!reset_n)
        halted |=> halted)
        else $error("halted fell before reset");

    assert property (@(posedge clock) disable iff (!reset_n)
        halted |=> !data_ram_write)
        else $error("store strobe after halt");

    // synchronous reset clears both outputs on the next clock
    assert property (@(posedge clock)
        !reset_n |=> (!halted && !data_ram_write))
        else $error("halted or data_ram_write set right after reset");

endmodule

bind shader_core shader_core_chk u_chk (
    .clock          (clock),
    .reset_n        (reset_n),
    .halted         (halted),
    .data_ram_write (data_ram_write)
);

// File: verif/shader_core_tb.sv
`timescale 1ns/1ps

module shader_core_tb;
    import core_pkg::*;

    localparam int address_width = 16;
    localparam int mem_words = 1 << (address_width - 2);
    localparam int timeout_cycles = 5000;

    logic                     clock;
    logic                     reset_n;
    logic                     run;
    logic                     halted;
    logic [address_width-1:0] inst_ram_address;
    word_t                    inst_ram_read_result;
    logic [address_width-1:0] data_ram_address;
    word_t                    data_ram_write_data;
    logic                     data_ram_write;
    word_t                    data_ram_read_result;

    word_t                    imem [mem_words];
    word_t                    dmem [mem_words];
    logic [address_width-1:0] inst_fetch_addr;
    logic [address_width-1:0] data_read_addr;
    logic [address_width-1:0] expected_addr [$];
    word_t                    expected_word [$];

    int     error_count;
    int     check_count;
    integer seed;
    logic   halt_seen;
    logic   halt_reached;
    logic   load_ok;

    shader_core #(
        .address_width (address_width)
    ) uut (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .halted               (halted),
        .inst_ram_address     (inst_ram_address),
        .inst_ram_read_result (inst_ram_read_result),
        .data_ram_address     (data_ram_address),
        .data_ram_write_data  (data_ram_write_data),
        .data_ram_write       (data_ram_write),
        .data_ram_read_result (data_ram_read_result)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // instruction RAM with one clock of read latency
    always @(posedge clock) begin
        inst_fetch_addr = inst_ram_address;
        #1;
        inst_ram_read_result = imem[inst_fetch_addr[address_width-1:2]];
    end

    // data RAM written on the strobe, read with the same latency
    always @(posedge clock) begin
        data_read_addr = data_ram_address;
        if (data_ram_write === 1'b1) begin
            dmem[data_ram_address[address_width-1:2]] = data_ram_write_data;
        end
        #1;
        data_ram_read_result = dmem[data_read_addr[address_width-1:2]];
    end

    // halted must stick and no store may follow it
    always @(negedge clock) begin
        if (reset_n) begin
            if (halt_seen && (halted !== 1'b1)) begin
                error_count++;
                $display("CHECK FAILED at %0t: halted dropped after the core stopped", $time);
            end
            if (halt_seen && (data_ram_write !== 1'b0)) begin
                error_count++;
                $display("CHECK FAILED at %0t: store strobe seen after halt", $time);
            end
            if (halted === 1'b1) begin
                halt_seen = 1'b1;
            end
        end
    end

    task automatic fill_memories();
        for (int i = 0; i < mem_words; i++) begin
            imem[i] = '0;
            dmem[i] = {16'hd0d0, 16'(i)};
        end
    endtask

    task automatic load_program();
        int                       fd;
        int                       n;
        string                    line;
        logic [7:0]               tag;
        logic [31:0]              addr;
        logic [31:0]              data;
        fd = $fopen("verif/program_input.txt", "r");
        load_ok = (fd != 0);
        if (!load_ok) begin
            $display("could not open verif/program_input.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if ((n > 0) && (line.getc(0) != "#")) begin
                    n = $sscanf(line, "%c %h %h", tag, addr, data);
                    if (n == 3) begin
                        case (tag)
                            "I": imem[addr[address_width-1:2]] = data;
                            "D": dmem[addr[address_width-1:2]] = data;
                            "E": begin
                                expected_addr.push_back(addr[address_width-1:0]);
                                expected_word.push_back(data);
                            end
                            default: begin
                                load_ok = 1'b0;
                                $display("unknown tag in program file: %s", line);
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
            if (expected_word.size() == 0) begin
                load_ok = 1'b0;
                $display("program file holds no expected words");
            end
        end
    endtask

    task automatic check_reset_state();
        @(negedge clock);
        check_count++;
        if ((halted !== 1'b0) || (data_ram_write !== 1'b0) || (inst_ram_address !== '0)) begin
            error_count++;
            $display("CHECK FAILED at %0t: after reset halted=%b write=%b fetch address=0x%h",
                     $time, halted, data_ram_write, inst_ram_address);
        end
    endtask

    // random stretches of run high and low
    task automatic drive_run_pauses();
        int r;
        int high_len;
        int low_len;
        forever begin
            r = $random(seed);
            high_len = 4 + (r & 15);
            low_len = 1 + ((r >> 4) & 3);
            repeat (high_len) @(posedge clock);
            #1;
            run = 1'b0;
            repeat (low_len) @(posedge clock);
            #1;
            run = 1'b1;
        end
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while ((halted !== 1'b1) && (cycles < timeout_cycles)) begin
            @(negedge clock);
            cycles++;
        end
        halt_reached = (halted === 1'b1);
        if (!halt_reached) begin
            error_count++;
            $display("timeout: the core did not halt within %0d cycles", timeout_cycles);
        end
    endtask

    task automatic compare_results();
        word_t got;
        for (int k = 0; k < expected_word.size(); k++) begin
            got = dmem[expected_addr[k][address_width-1:2]];
            check_count++;
            if (got !== expected_word[k]) begin
                error_count++;
                $display("CHECK FAILED at %0t: data word at 0x%h is 0x%h, expected 0x%h",
                         $time, expected_addr[k], got, expected_word[k]);
            end
        end
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        seed = 63869;
        halt_seen = 1'b0;
        halt_reached = 1'b0;
        reset_n = 1'b0;
        run = 1'b0;
        inst_ram_read_result = '0;
        data_ram_read_result = '0;
        fill_memories();
        load_program();
        if (load_ok) begin
            repeat (3) @(posedge clock);
            #1;
            reset_n = 1'b1;
            run = 1'b1;
            check_reset_state();
            fork
                drive_run_pauses();
            join_none
            wait_for_halt();
            if (halt_reached) begin
                // let a stray store show up before memory is compared
                repeat (20) @(negedge clock);
                compare_results();
            end
        end else begin
            error_count++;
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
